//--- rtl/mem_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data word and chip half widths of the external memory pair
// one word is two 16-bit chips side by side, low half in chip 0
// the address width is a module parameter, only its default lives here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_types_pkg;

   localparam int WORD_W = 32;
   localparam int HALF_W = 16;

   localparam int ADDR_W_DEF = 10;   // default word address width

   // full data word on both ports
   typedef logic [WORD_W-1:0] word_t;

   // one chip's share of a word
   typedef logic [HALF_W-1:0] half_t;

endpackage

//--- rtl/port_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// requester identity and pipeline depth
// latency counts edges from the accepting edge to the answer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package port_pkg;

   // owner of a transaction
   typedef logic src_t;

   localparam src_t SRC_CPU = 1'b0;   // processor data port
   localparam src_t SRC_VGA = 1'b1;   // display fetch port

   // arbitrate, access, return
   localparam int PIPE_LAT = 3;

endpackage

//--- rtl/mem_txn_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one issued transaction, arbiter to memory stage
// valid is a single-cycle strobe, no back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface mem_txn_if
   import mem_types_pkg::*, port_pkg::*;
#(
   parameter int ADDR_W = ADDR_W_DEF
);
   logic              valid;
   logic              write;
   src_t              src;
   logic [ADDR_W-1:0] addr;
   word_t             wdata;

   modport issue (output valid, write, src, addr, wdata);
   modport take  (input  valid, write, src, addr, wdata);

endinterface

//--- rtl/mem_resp_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// completed access, memory stage to return stage
// rdata only carries meaning when write is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface mem_resp_if
   import mem_types_pkg::*, port_pkg::*;
();
   logic  valid;
   logic  write;
   src_t  src;
   word_t rdata;

   modport put (output valid, write, src, rdata);
   modport get (input  valid, write, src, rdata);

endinterface

//--- rtl/mem_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-port request arbiter, display has priority
// each port keeps at most one request outstanding, so a pending
// slot is always free when a new req arrives
// a processor request that loses a collision goes out one edge later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_arbiter
   import mem_types_pkg::*, port_pkg::*;
#(
   parameter int ADDR_W = ADDR_W_DEF
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cpu_req,
   input  logic              cpu_write,
   input  logic [ADDR_W-1:0] cpu_addr,
   input  word_t             cpu_wdata,
   input  logic              vga_req,
   input  logic [ADDR_W-1:0] vga_addr,
   mem_txn_if.issue          txn
);

   logic              cpu_pend;
   logic              cpu_write_q;
   logic [ADDR_W-1:0] cpu_addr_q;
   word_t             cpu_wdata_q;

   logic              take_vga;
   logic              take_cpu;
   logic              cpu_sel_write;
   logic [ADDR_W-1:0] cpu_sel_addr;
   word_t             cpu_sel_wdata;

   assign take_vga = vga_req;   // display issues on the edge that sees it
   assign take_cpu = ~take_vga & (cpu_pend | cpu_req);

   // a held slot wins over the live inputs
   assign cpu_sel_write = cpu_pend ? cpu_write_q : cpu_write;
   assign cpu_sel_addr  = cpu_pend ? cpu_addr_q  : cpu_addr;
   assign cpu_sel_wdata = cpu_pend ? cpu_wdata_q : cpu_wdata;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cpu_pend  <= 1'b0;
         txn.valid <= 1'b0;
      end else begin
         cpu_pend  <= (cpu_pend | cpu_req) & ~take_cpu;
         txn.valid <= take_vga | take_cpu;
      end
   end

   // capture every processor request, whether it issues now or waits
   always_ff @(posedge clk) begin
      if (cpu_req) begin
         cpu_write_q <= cpu_write;
         cpu_addr_q  <= cpu_addr;
         cpu_wdata_q <= cpu_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (take_vga) begin
         txn.write <= 1'b0;        // display never writes
         txn.src   <= SRC_VGA;
         txn.addr  <= vga_addr;
      end else if (take_cpu) begin
         txn.write <= cpu_sel_write;
         txn.src   <= SRC_CPU;
         txn.addr  <= cpu_sel_addr;
         txn.wdata <= cpu_sel_wdata;
      end
   end

endmodule

//--- rtl/sram_pair.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two 16-bit chip models holding one 32-bit word per address
// contents are not cleared by reset
// read data appears one edge after txn valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sram_pair
   import mem_types_pkg::*;
#(
   parameter int ADDR_W = ADDR_W_DEF
) (
   input  logic      clk,
   mem_txn_if.take   txn,
   mem_resp_if.put   resp
);

   localparam int DEPTH = 2 ** ADDR_W;

   half_t bank0 [DEPTH];   // low half chip
   half_t bank1 [DEPTH];   // high half chip

   half_t lo_q;
   half_t hi_q;

   always_ff @(posedge clk) begin
      if (txn.valid) begin
         if (txn.write) begin
            bank0[txn.addr] <= txn.wdata[HALF_W-1:0];
            bank1[txn.addr] <= txn.wdata[WORD_W-1:HALF_W];
         end else begin
            lo_q <= bank0[txn.addr];
            hi_q <= bank1[txn.addr];
         end
      end
   end

   // tag travels alongside the access so the result keeps its owner
   always_ff @(posedge clk) begin
      resp.valid <= txn.valid;   // low while arbiter is held in reset
      resp.write <= txn.write;
      resp.src   <= txn.src;
   end

   assign resp.rdata = {hi_q, lo_q};

endmodule

//--- rtl/mem_return.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// return stage, last of the PIPE_LAT stages
// ready and done are one-cycle pulses
// rdata outputs hold until the next read of the same port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_return
   import mem_types_pkg::*, port_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   mem_resp_if.get  resp,
   output word_t    cpu_rdata,
   output logic     cpu_ready,
   output logic     cpu_done,
   output word_t    vga_rdata,
   output logic     vga_ready
);

   logic cpu_rd;
   logic cpu_wr;
   logic vga_rd;

   assign cpu_rd = resp.valid & ~resp.write & (resp.src == SRC_CPU);
   assign cpu_wr = resp.valid &  resp.write & (resp.src == SRC_CPU);
   assign vga_rd = resp.valid & ~resp.write & (resp.src == SRC_VGA);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cpu_ready <= 1'b0;
         cpu_done  <= 1'b0;
         vga_ready <= 1'b0;
      end else begin
         cpu_ready <= cpu_rd;
         cpu_done  <= cpu_wr;
         vga_ready <= vga_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (cpu_rd) begin
         cpu_rdata <= resp.rdata;
      end
      if (vga_rd) begin
         vga_rdata <= resp.rdata;
      end
   end

endmodule

//--- rtl/caddr_mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared memory path, processor and display ports
// single clock, one outstanding request per port
// display port is read only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module caddr_mem_top
   import mem_types_pkg::*;
#(
   parameter int ADDR_W = ADDR_W_DEF
) (
   input  logic              clk,
   input  logic              rst_n,

   input  logic              cpu_req,
   input  logic              cpu_write,
   input  logic [ADDR_W-1:0] cpu_addr,
   input  word_t             cpu_wdata,
   output word_t             cpu_rdata,
   output logic              cpu_ready,
   output logic              cpu_done,

   input  logic              vga_req,
   input  logic [ADDR_W-1:0] vga_addr,
   output word_t             vga_rdata,
   output logic              vga_ready
);

   mem_txn_if #(.ADDR_W(ADDR_W)) txn ();
   mem_resp_if                   resp ();

   mem_arbiter #(.ADDR_W(ADDR_W)) arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .cpu_req   (cpu_req),
      .cpu_write (cpu_write),
      .cpu_addr  (cpu_addr),
      .cpu_wdata (cpu_wdata),
      .vga_req   (vga_req),
      .vga_addr  (vga_addr),
      .txn       (txn.issue)
   );

   sram_pair #(.ADDR_W(ADDR_W)) sram (
      .clk  (clk),
      .txn  (txn.take),
      .resp (resp.put)
   );

   mem_return ret (
      .clk       (clk),
      .rst_n     (rst_n),
      .resp      (resp.get),
      .cpu_rdata (cpu_rdata),
      .cpu_ready (cpu_ready),
      .cpu_done  (cpu_done),
      .vga_rdata (vga_rdata),
      .vga_ready (vga_ready)
   );

endmodule

//--- sim/caddr_mem_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol and latency properties of caddr_mem_top
// assumes each port keeps at most one request outstanding
// fail_cnt counts failures for the closing summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module caddr_mem_props
   import mem_types_pkg::*, port_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic cpu_req,
   input logic cpu_write,
   input logic vga_req,
   input logic cpu_ready,
   input logic cpu_done,
   input logic vga_ready
);

   int   fail_cnt = 0;
   logic seen_req;
   logic cpu_ans;
   logic cpu_free;    // processor request with no display request beside it
   logic cpu_clash;   // both ports in the same cycle

   assign cpu_ans   = cpu_ready | cpu_done;
   assign cpu_free  = cpu_req & ~vga_req;
   assign cpu_clash = cpu_req & vga_req;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         seen_req <= 1'b0;
      end else if (cpu_req | vga_req) begin
         seen_req <= 1'b1;
      end
   end

   a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      !seen_req |-> !(cpu_ans | vga_ready)) else begin
      fail_cnt++;
      $error("answer pulse seen before any request");
   end

   a_cpu_free_lat: assert property (@(posedge clk) disable iff (!rst_n)
      $past(cpu_free, PIPE_LAT) |-> cpu_ans) else begin
      fail_cnt++;
      $error("uncontended processor request not answered after PIPE_LAT edges");
   end

   a_cpu_clash_lat: assert property (@(posedge clk) disable iff (!rst_n)
      $past(cpu_clash, PIPE_LAT + 1) |-> cpu_ans) else begin
      fail_cnt++;
      $error("processor request beside a display request not answered one edge late");
   end

   a_vga_lat: assert property (@(posedge clk) disable iff (!rst_n)
      $past(vga_req, PIPE_LAT) |-> vga_ready) else begin
      fail_cnt++;
      $error("display request not answered after PIPE_LAT edges");
   end

   // every pulse must belong to a request of the matching kind
   a_done_owned: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_done |-> $past(cpu_free & cpu_write, PIPE_LAT)
                   || $past(cpu_clash & cpu_write, PIPE_LAT + 1)) else begin
      fail_cnt++;
      $error("cpu_done pulse without a matching processor write");
   end

   a_ready_owned: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_ready |-> $past(cpu_free & ~cpu_write, PIPE_LAT)
                    || $past(cpu_clash & ~cpu_write, PIPE_LAT + 1)) else begin
      fail_cnt++;
      $error("cpu_ready pulse without a matching processor read");
   end

   a_vga_owned: assert property (@(posedge clk) disable iff (!rst_n)
      vga_ready |-> $past(vga_req, PIPE_LAT)) else begin
      fail_cnt++;
      $error("vga_ready pulse without a matching display read");
   end

endmodule

bind caddr_mem_top caddr_mem_props props (
   .clk       (clk),
   .rst_n     (rst_n),
   .cpu_req   (cpu_req),
   .cpu_write (cpu_write),
   .vga_req   (vga_req),
   .cpu_ready (cpu_ready),
   .cpu_done  (cpu_done),
   .vga_ready (vga_ready)
);

//--- sim/caddr_mem_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for caddr_mem_top with a 16-word address space
// every word is written once before any read, memory is not reset
// shadow memory follows cpu_done, reads are checked on each ready pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module caddr_mem_tb
   import mem_types_pkg::*, port_pkg::*;
();

   localparam int ADDR_W     = 4;
   localparam int DEPTH      = 2 ** ADDR_W;
   localparam int PERIOD     = 20;
   localparam int RST_CYCLES = 8;
   localparam int N_CLASH    = 12;    // forced same-cycle pairs
   localparam int N_RAND     = 150;   // random requests per port
   localparam int N_TXN      = DEPTH + 2 * N_CLASH + 2 * N_RAND;
   localparam logic [31:0] SEED = 32'h029fff7a;

   logic              clk;
   logic              rst_n;
   logic              cpu_req;
   logic              cpu_write;
   logic [ADDR_W-1:0] cpu_addr;
   word_t             cpu_wdata;
   word_t             cpu_rdata;
   logic              cpu_ready;
   logic              cpu_done;
   logic              vga_req;
   logic [ADDR_W-1:0] vga_addr;
   word_t             vga_rdata;
   logic              vga_ready;

   word_t             shadow [DEPTH];
   logic              cpu_busy;
   logic              cpu_busy_write;
   logic [ADDR_W-1:0] cpu_busy_addr;
   word_t             cpu_busy_wdata;
   logic              vga_busy;
   logic [ADDR_W-1:0] vga_busy_addr;
   int                chk_errors;
   int                n_checks;

   caddr_mem_top #(.ADDR_W(ADDR_W)) DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .cpu_req   (cpu_req),
      .cpu_write (cpu_write),
      .cpu_addr  (cpu_addr),
      .cpu_wdata (cpu_wdata),
      .cpu_rdata (cpu_rdata),
      .cpu_ready (cpu_ready),
      .cpu_done  (cpu_done),
      .vga_req   (vga_req),
      .vga_addr  (vga_addr),
      .vga_rdata (vga_rdata),
      .vga_ready (vga_ready)
   );

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   function automatic word_t fill_word(input int a);
      half_t base;
      base = half_t'(a);
      return {base ^ 16'ha5c3, base ^ 16'h3c5a};
   endfunction

   function automatic word_t make_word();
      half_t lo;
      half_t hi;
      lo = half_t'($urandom);
      hi = half_t'($urandom);
      if (hi == lo) begin
         hi = ~lo;   // halves must differ
      end
      return {hi, lo};
   endfunction

   function automatic logic [ADDR_W-1:0] rand_addr();
      return ADDR_W'($urandom_range(DEPTH - 1, 0));
   endfunction

   task automatic issue_cpu(input logic write, input logic [ADDR_W-1:0] addr,
                            input word_t data);
      cpu_req        = 1'b1;
      cpu_write      = write;
      cpu_addr       = addr;
      cpu_wdata      = data;
      cpu_busy       = 1'b1;
      cpu_busy_write = write;
      cpu_busy_addr  = addr;
      cpu_busy_wdata = data;
   endtask

   task automatic issue_vga(input logic [ADDR_W-1:0] addr);
      vga_req       = 1'b1;
      vga_addr      = addr;
      vga_busy      = 1'b1;
      vga_busy_addr = addr;
   endtask

   // pulses are stable at the falling edge
   task automatic collect_answers();
      if (cpu_done) begin
         assert (cpu_busy && cpu_busy_write) else begin
            chk_errors++;
            $display("cpu_done arrived with no processor write outstanding");
         end
         shadow[cpu_busy_addr] = cpu_busy_wdata;
         cpu_busy = 1'b0;
      end
      if (cpu_ready) begin
         assert (cpu_busy && !cpu_busy_write) else begin
            chk_errors++;
            $display("cpu_ready arrived with no processor read outstanding");
         end
         assert (cpu_rdata[HALF_W-1:0] == shadow[cpu_busy_addr][HALF_W-1:0]) else begin
            chk_errors++;
            $display("Error: cpu_rdata[15:0] = %h, expected %h at address %h",
                     cpu_rdata[HALF_W-1:0], shadow[cpu_busy_addr][HALF_W-1:0], cpu_busy_addr);
         end
         assert (cpu_rdata[WORD_W-1:HALF_W] == shadow[cpu_busy_addr][WORD_W-1:HALF_W]) else begin
            chk_errors++;
            $display("Error: cpu_rdata[31:16] = %h, expected %h at address %h",
                     cpu_rdata[WORD_W-1:HALF_W], shadow[cpu_busy_addr][WORD_W-1:HALF_W],
                     cpu_busy_addr);
         end
         n_checks++;
         cpu_busy = 1'b0;
      end
      if (vga_ready) begin
         assert (vga_busy && vga_rdata == shadow[vga_busy_addr]) else begin
            chk_errors++;
            $display("Error: vga_rdata = %h, expected %h at address %h",
                     vga_rdata, shadow[vga_busy_addr], vga_busy_addr);
         end
         n_checks++;
         vga_busy = 1'b0;
      end
   endtask

   task automatic next_cycle();
      @(negedge clk);
      cpu_req = 1'b0;
      vga_req = 1'b0;
      collect_answers();
   endtask

   task automatic wait_idle();
      while (cpu_busy || vga_busy) begin
         next_cycle();
      end
   endtask

   initial begin
      logic [ADDR_W-1:0] a;
      int                cpu_left;
      int                vga_left;
      rst_n      = 1'b0;
      cpu_req    = 1'b0;
      cpu_write  = 1'b0;
      cpu_addr   = '0;
      cpu_wdata  = '0;
      vga_req    = 1'b0;
      vga_addr   = '0;
      cpu_busy   = 1'b0;
      vga_busy   = 1'b0;
      chk_errors = 0;
      n_checks   = 0;
      void'($urandom(SEED));
      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      repeat (PIPE_LAT + 1) next_cycle();   // idle window after reset
      for (int i = 0; i < DEPTH; i++) begin   // preload through the processor port
         next_cycle();
         issue_cpu(1'b1, ADDR_W'(i), fill_word(i));
         wait_idle();
      end
      for (int i = 0; i < N_CLASH; i++) begin   // both ports in the same cycle
         next_cycle();
         a = rand_addr();
         issue_cpu(i[0], a, make_word());
         issue_vga(i[1] ? a : rand_addr());
         wait_idle();
      end
      cpu_left = N_RAND;
      vga_left = N_RAND;
      while (cpu_left > 0 || vga_left > 0) begin
         next_cycle();
         if (!cpu_busy && cpu_left > 0 && $urandom_range(3, 0) != 0) begin
            issue_cpu($urandom_range(1, 0) == 1, rand_addr(), make_word());
            cpu_left--;
         end
         if (!vga_busy && vga_left > 0 && $urandom_range(3, 0) != 0) begin
            a = rand_addr();
            if (cpu_busy && cpu_busy_write && $urandom_range(1, 0) == 1) begin
               a = cpu_busy_addr;   // chase a fresh write
            end
            issue_vga(a);
            vga_left--;
         end
      end
      wait_idle();
      repeat (PIPE_LAT + 2) next_cycle();
      $display("read checks %0d, check errors %0d, property errors %0d",
               n_checks, chk_errors, DUT.props.fail_cnt);
      if (chk_errors == 0 && DUT.props.fail_cnt == 0 && n_checks > 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #((RST_CYCLES + N_TXN * 10) * PERIOD);
      $display("timeout, traffic did not complete within %0d transactions of time", N_TXN);
      $display("Test failures found");
      $finish;
   end

endmodule

//--- project.f
rtl/mem_types_pkg.sv
rtl/port_pkg.sv
rtl/mem_txn_if.sv
rtl/mem_resp_if.sv
rtl/mem_arbiter.sv
rtl/sram_pair.sv
rtl/mem_return.sv
rtl/caddr_mem_top.sv
sim/caddr_mem_props.sv
sim/caddr_mem_tb.sv

//--- Makefile
# Verilator simulation of the shared memory path

TOP := caddr_mem_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^All tests passed!$$" sim.log

clean:
	rm -rf obj_dir sim.log
